/* hdl/knight_cfg.svh */
`ifndef KNIGHT_CFG_SVH
`define KNIGHT_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Build-time configuration for the knight command subsystem
////////////////////////////////////////////////////////////////////////////

`define KNIGHT_FAST_SIM 1  // 1 selects big steps for short simulations

// Forward speed steps, applied once per gyro reading
`define KNIGHT_INC_STEP ((`KNIGHT_FAST_SIM != 0) ? 10'h020 : 10'h003)
`define KNIGHT_DEC_STEP ((`KNIGHT_FAST_SIM != 0) ? 10'h040 : 10'h006)

// Heading nudges from the side IR sensors
`define KNIGHT_NUDGE_POS ((`KNIGHT_FAST_SIM != 0) ? 12'h1FF : 12'h05F)
`define KNIGHT_NUDGE_NEG ((`KNIGHT_FAST_SIM != 0) ? 12'hE00 : 12'hFA1)

// Error magnitude below which a move may start
`define KNIGHT_ALIGN_THRESH 12'h02C

`endif

/* hdl/knight_pkg.sv */
package knight_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command opcodes, taken from cmd[15:12]
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    CAL     = 4'h2,  // Gyro calibration
    MOVE    = 4'h4,  // Plain move
    FANFARE = 4'h5,  // Move, then the charge tune
    TOUR    = 4'h6   // Hand off to the tour solver
  } opcode_t;

  typedef logic signed [11:0] heading_t;  // Heading or heading error
  typedef logic [9:0]         speed_t;    // Forward speed
  typedef logic [3:0]         squares_t;  // Squares to travel

  ////////////////////////////////////////////////////////////////////////////
  // Command FSM states
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,       // Waiting for a command
    CALIBRATE,  // Waiting for cal_done
    TOUR_GO,    // One cycle of tour_go
    ALIGN,      // Turning onto the heading
    RAMP_UP,    // Speeding up, counting lines
    RAMP_DOWN,  // Slowing to a stop
    RESPOND     // Holding resp_valid
  } ctrl_state_t;

endpackage

/* hdl/ir_sync.sv */
`timescale 1ns/1ns

module ir_sync (
  input  logic clk,
  input  logic rst_n,
  input  logic lft_ir,     // Async left sensor
  input  logic cntr_ir,    // Async centre sensor
  input  logic rght_ir,    // Async right sensor
  output logic lft_s,      // Synced left level
  output logic rght_s,     // Synced right level
  output logic cntr_rise   // One-cycle pulse per line crossing
);

  logic lft_meta, rght_meta, cntr_meta;  // First stage, may go metastable
  logic cntr_s;                          // Synced centre level
  logic cntr_d;                          // Centre level one cycle older

  // Two-stage synchronizers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lft_meta  <= 1'b0;
      lft_s     <= 1'b0;
      rght_meta <= 1'b0;
      rght_s    <= 1'b0;
      cntr_meta <= 1'b0;
      cntr_s    <= 1'b0;
    end else begin
      lft_meta  <= lft_ir;
      lft_s     <= lft_meta;
      rght_meta <= rght_ir;
      rght_s    <= rght_meta;
      cntr_meta <= cntr_ir;
      cntr_s    <= cntr_meta;
    end
  end

  // Rising edge only, so a long dwell on the line counts once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_d    <= 1'b0;
      cntr_rise <= 1'b0;
    end else begin
      cntr_d    <= cntr_s;              // Delayed copy for edge compare
      cntr_rise <= cntr_s & ~cntr_d;    // New high, old low
    end
  end

endmodule

/* hdl/square_counter.sv */
`timescale 1ns/1ns

module square_counter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_move,  // Load pulse from the FSM
  input  knight_pkg::squares_t squares,    // Square count from cmd[3:0]
  input  logic                cntr_rise,   // One pulse per line edge
  output logic                move_done    // Crossings reached the target
);

  import knight_pkg::*;

  squares_t   sq_q;      // Squares for the current move
  logic [4:0] cross_q;   // Line crossings so far
  logic [4:0] target;    // Two lines per square

  assign target = {sq_q, 1'b0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sq_q    <= '0;
      cross_q <= '0;
    end else if (start_move) begin
      sq_q    <= squares;   // New move, new target
      cross_q <= '0;        // Restart the count
    end else if (cntr_rise && (cross_q != 5'd31)) begin
      cross_q <= cross_q + 5'd1;  // Saturate at 31
    end
  end

  assign move_done = (cross_q == target);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Once the target is reached, another line edge before the next move
  // would carry the count past it
  a_no_overshoot: assert property (
    @(posedge clk) disable iff (!rst_n)
    (move_done && !start_move) |-> !cntr_rise
  );

endmodule

/* hdl/heading_err.sv */
`timescale 1ns/1ns
`include "knight_cfg.svh"

module heading_err (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_move,   // Capture strobe
  input  logic [7:0]          cmd_heading,  // Heading field, cmd[11:4]
  input  knight_pkg::heading_t heading,     // Gyro heading
  input  logic                lft_s,        // Drifted toward left line
  input  logic                rght_s,       // Drifted toward right line
  output knight_pkg::heading_t error        // To the PID
);

  import knight_pkg::*;

  localparam heading_t NUDGE_POS = `KNIGHT_NUDGE_POS;
  localparam heading_t NUDGE_NEG = `KNIGHT_NUDGE_NEG;

  heading_t desired_q;  // Heading asked for by the command
  heading_t nudge;      // Side sensor correction

  ////////////////////////////////////////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_q <= '0;
    end else if (start_move) begin
      if (cmd_heading == 8'h00)
        desired_q <= '0;                     // Zero stays exactly zero
      else
        desired_q <= {cmd_heading, 4'hF};    // Pad low nibble with ones
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error with nudge
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (lft_s)
      nudge = NUDGE_POS;   // Left wins if both are set
    else if (rght_s)
      nudge = NUDGE_NEG;
    else
      nudge = '0;
  end

  assign error = heading - desired_q + nudge;  // Wraps modulo 4096

endmodule

/* hdl/speed_ramp.sv */
`timescale 1ns/1ns
`include "knight_cfg.svh"

module speed_ramp #(
  parameter knight_pkg::speed_t INC_STEP = `KNIGHT_INC_STEP,  // Up step per reading
  parameter knight_pkg::speed_t DEC_STEP = `KNIGHT_DEC_STEP   // Down step per reading
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_move,   // Clears the speed
  input  logic              ramp_up,      // Speed up on readings
  input  logic              ramp_down,    // Slow down on readings
  input  logic              heading_rdy,  // New gyro reading
  output knight_pkg::speed_t frwrd,       // Forward speed
  output logic              speed_zero    // Robot has stopped
);

  import knight_pkg::*;

  logic   at_max;     // Two top bits set
  speed_t frwrd_nxt;  // Speed after this reading

  assign at_max     = &frwrd[9:8];
  assign speed_zero = (frwrd == '0);

  always_comb begin
    frwrd_nxt = frwrd;
    if (ramp_up) begin
      if (!at_max)
        frwrd_nxt = frwrd + INC_STEP;
    end else if (ramp_down) begin
      if (frwrd > DEC_STEP)
        frwrd_nxt = frwrd - DEC_STEP;
      else
        frwrd_nxt = '0;                 // Clamp, never wrap
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (start_move)
      frwrd <= '0;           // Every move starts from rest
    else if (heading_rdy)
      frwrd <= frwrd_nxt;    // Step only on gyro updates
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_one_dir: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ramp_up && ramp_down)
  );

endmodule

/* hdl/cmd_proc.sv */
`timescale 1ns/1ns
`include "knight_cfg.svh"

module cmd_proc (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [15:0]         cmd,         // Command word from the link
  input  logic                cmd_valid,
  input  logic                resp_ready,
  input  logic                cal_done,    // Gyro calibration finished
  input  knight_pkg::heading_t error,      // Current heading error
  input  logic                move_done,   // All lines crossed
  input  logic                speed_zero,  // Speed back at zero
  output logic                cmd_ready,
  output logic                resp_valid,
  output logic                start_move,  // Accept pulse for moves
  output logic                strt_cal,    // Kick off gyro calibration
  output logic                tour_go,     // Hand off to tour solver
  output logic                fanfare_go,  // Start the charge tune
  output logic                moving,      // Lets the gyro integrate yaw
  output logic                ramp_up,
  output logic                ramp_down
);

  import knight_pkg::*;

  localparam heading_t ALIGN_THRESH = `KNIGHT_ALIGN_THRESH;

  ctrl_state_t state, nxt_state;
  opcode_t     cmd_op;    // Opcode on the input bus
  opcode_t     op_q;      // Opcode of the command being run
  logic        accept;    // Command transfers this cycle
  logic        aligned;   // Error inside the window

  ////////////////////////////////////////////////////////////////////////////
  // Command intake
  ////////////////////////////////////////////////////////////////////////////

  assign cmd_op     = opcode_t'(cmd[15:12]);
  assign cmd_ready  = (state == IDLE);         // Held low while a response waits
  assign accept     = cmd_valid & cmd_ready;
  assign start_move = accept & ((cmd_op == MOVE) | (cmd_op == FANFARE));

  always_ff @(posedge clk) begin
    if (accept)
      op_q <= cmd_op;   // Keep our own copy, the bus may change
  end

  // Symmetric window around zero
  assign aligned = (error < ALIGN_THRESH) && (error > -ALIGN_THRESH);

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    case (state)
      IDLE: begin
        if (accept) begin
          case (cmd_op)
            CAL:           nxt_state = CALIBRATE;
            TOUR:          nxt_state = TOUR_GO;
            MOVE, FANFARE: nxt_state = ALIGN;
            default:       nxt_state = IDLE;   // Unknown opcode is dropped
          endcase
        end
      end
      CALIBRATE: if (cal_done)   nxt_state = RESPOND;
      TOUR_GO:                   nxt_state = IDLE;   // No response for a tour
      ALIGN:     if (aligned)    nxt_state = RAMP_UP;
      RAMP_UP:   if (move_done)  nxt_state = RAMP_DOWN;
      RAMP_DOWN: if (speed_zero) nxt_state = RESPOND;
      RESPOND:   if (resp_ready) nxt_state = IDLE;
      default:                   nxt_state = IDLE;
    endcase
  end

  // Calibration strobe lands in the first CALIBRATE cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      strt_cal <= 1'b0;
    else
      strt_cal <= accept && (cmd_op == CAL);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs decoded from state
  ////////////////////////////////////////////////////////////////////////////

  assign tour_go    = (state == TOUR_GO);
  assign resp_valid = (state == RESPOND);
  assign ramp_up    = (state == RAMP_UP);
  assign ramp_down  = (state == RAMP_DOWN);
  assign moving     = (state == ALIGN) || ramp_up || ramp_down;

  // Tune starts as the robot begins to slow
  assign fanfare_go = ramp_up && move_done && (op_q == FANFARE);

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_cal_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) strt_cal |=> !strt_cal
  );

  a_tour_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) tour_go |=> !tour_go
  );

  a_fanfare_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) fanfare_go |=> !fanfare_go
  );

  a_no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n) !(cmd_ready && resp_valid)
  );

endmodule

/* hdl/knight_ctrl_top.sv */
`timescale 1ns/1ns

module knight_ctrl_top (
  input  logic                clk,
  input  logic                rst_n,
  // Command link
  input  logic [15:0]         cmd,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  // Completion response
  output logic                resp_valid,
  input  logic                resp_ready,
  // Gyro
  output logic                strt_cal,
  input  logic                cal_done,
  input  knight_pkg::heading_t heading,
  input  logic                heading_rdy,
  // Line sensors, asynchronous
  input  logic                lft_ir,
  input  logic                cntr_ir,
  input  logic                rght_ir,
  // To PID, motors, piezo and tour solver
  output knight_pkg::heading_t error,
  output knight_pkg::speed_t   frwrd,
  output logic                moving,
  output logic                tour_go,
  output logic                fanfare_go
);

  logic lft_s, rght_s, cntr_rise;    // Synced sensor signals
  logic start_move;                  // Move accepted
  logic move_done;                   // Target crossings reached
  logic ramp_up, ramp_down;          // Speed direction
  logic speed_zero;                  // Robot stopped

  ir_sync u_ir_sync (
    .clk       (clk),
    .rst_n     (rst_n),
    .lft_ir    (lft_ir),
    .cntr_ir   (cntr_ir),
    .rght_ir   (rght_ir),
    .lft_s     (lft_s),
    .rght_s    (rght_s),
    .cntr_rise (cntr_rise)
  );

  square_counter u_square_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_move (start_move),
    .squares    (cmd[3:0]),
    .cntr_rise  (cntr_rise),
    .move_done  (move_done)
  );

  heading_err u_heading_err (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_move  (start_move),
    .cmd_heading (cmd[11:4]),
    .heading     (heading),
    .lft_s       (lft_s),
    .rght_s      (rght_s),
    .error       (error)
  );

  speed_ramp u_speed_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_move  (start_move),
    .ramp_up     (ramp_up),
    .ramp_down   (ramp_down),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .speed_zero  (speed_zero)
  );

  cmd_proc u_cmd_proc (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .resp_ready (resp_ready),
    .cal_done   (cal_done),
    .error      (error),
    .move_done  (move_done),
    .speed_zero (speed_zero),
    .cmd_ready  (cmd_ready),
    .resp_valid (resp_valid),
    .start_move (start_move),
    .strt_cal   (strt_cal),
    .tour_go    (tour_go),
    .fanfare_go (fanfare_go),
    .moving     (moving),
    .ramp_up    (ramp_up),
    .ramp_down  (ramp_down)
  );

endmodule

/* bench/knight_tb.sv */
`timescale 1ns/1ns
`include "knight_cfg.svh"

module knight_tb;

  import knight_pkg::*;

  localparam speed_t INC_STEP = `KNIGHT_INC_STEP;
  localparam speed_t DEC_STEP = `KNIGHT_DEC_STEP;

  logic        clk, rst_n;
  logic [15:0] cmd;
  logic        cmd_valid, cmd_ready, resp_valid, resp_ready;
  logic        strt_cal, cal_done, heading_rdy;
  heading_t    heading, error;
  speed_t      frwrd;
  logic        lft_ir, cntr_ir, rght_ir;
  logic        moving, tour_go, fanfare_go;

  integer      seed = 32'hb3c19cb2;
  logic        rdy_en;                          // Random gyro readings on
  speed_t      exp_frwrd;                       // Model of the speed register
  logic        fell, saw_sat, saw_clamp;        // Ramp events seen by the model
  int          n_cal, n_tour, n_fanfare;        // Pulse counters
  ctrl_state_t dut_state;

  assign dut_state = i_knight_ctrl_top.u_cmd_proc.state;  // FSM state for the model

  knight_ctrl_top i_knight_ctrl_top (.*);

  always #5 clk = ~clk;  // 10 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Reference and compare
  ////////////////////////////////////////////////////////////////////////////

  function automatic heading_t desired_heading(logic [7:0] field);
    return (field == 8'h00) ? heading_t'(0) : heading_t'({field, 4'hF});  // Ones pad
  endfunction

  function automatic heading_t exp_error(heading_t hd, logic [7:0] field,
                                         logic lft, logic rght);
    heading_t nudge;
    nudge = lft ? heading_t'(`KNIGHT_NUDGE_POS) :
            rght ? heading_t'(`KNIGHT_NUDGE_NEG) : heading_t'(0);  // Left first
    return hd - desired_heading(field) + nudge;                      // Modulo 4096
  endfunction

  task automatic stop_on_failure();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic timed_out(string what);
    $display("Timed out waiting for %s", what);
    stop_on_failure();
  endtask

  task automatic check_error(heading_t got, heading_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED error: got 0x%h, expected 0x%h", got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_speed(speed_t got, speed_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED frwrd: got 0x%h, expected 0x%h", got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // Speed model, steps only on gyro readings
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_frwrd <= '0;
      fell      <= 1'b0;
      saw_sat   <= 1'b0;
      saw_clamp <= 1'b0;
    end else if (cmd_valid && cmd_ready &&
                 (cmd[15:12] == MOVE || cmd[15:12] == FANFARE)) begin
      exp_frwrd <= '0;                                   // New move starts at rest
      fell      <= 1'b0;
    end else if (heading_rdy) begin
      if (dut_state == RAMP_UP) begin
        if (exp_frwrd[9:8] == 2'b11)
          saw_sat <= 1'b1;                               // Held at the top
        else
          exp_frwrd <= exp_frwrd + INC_STEP;
      end else if (dut_state == RAMP_DOWN) begin
        if (exp_frwrd != '0)
          fell <= 1'b1;
        if (exp_frwrd < DEC_STEP) begin
          exp_frwrd <= '0;                               // Clamp at zero
          if (exp_frwrd != '0)
            saw_clamp <= 1'b1;
        end else begin
          exp_frwrd <= exp_frwrd - DEC_STEP;
        end
      end
    end
  end

  // Compare on the falling edge where registered outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      check_speed(frwrd, exp_frwrd);
      if (frwrd != '0)
        check_flag("moving", moving, 1'b1);   // Robot rolls only while moving
      if (strt_cal)
        n_cal++;
      if (tour_go)
        n_tour++;
      if (fanfare_go) begin
        n_fanfare++;
        check_flag("frwrd_fell", fell, 1'b0); // Tune before slowing
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    int rnd;
    @(negedge clk);
    rnd = $random(seed);
    heading_rdy = rdy_en ? rnd[0] : 1'b0;  // Random gyro updates
  endtask

  task automatic set_rdy(logic en);
    rdy_en = en;
    if (!en)
      heading_rdy = 1'b0;                  // Freeze speed from the next edge
  endtask

  task automatic send_cmd(logic [15:0] word);
    int t;
    t = 0;
    cmd       = word;
    cmd_valid = 1'b1;
    while (!cmd_ready) begin
      next_cycle();
      t++;
      if (t > 50)
        timed_out("cmd_ready");
    end
    next_cycle();                          // Transfer edge passed
    cmd_valid = 1'b0;
    cmd       = 16'($random(seed));        // Bus junk must not matter now
  endtask

  task automatic take_response(logic stall);
    int t;
    int n;
    t = 0;
    while (!resp_valid) begin
      next_cycle();
      t++;
      if (t > 400)
        timed_out("resp_valid");
    end
    if (stall) begin
      repeat (3) begin
        n = 1 + ($random(seed) & 7);
        repeat (n) begin
          check_flag("resp_valid", resp_valid, 1'b1);
          check_flag("cmd_ready", cmd_ready, 1'b0);   // Back-pressure
          next_cycle();
        end
      end
    end
    resp_ready = 1'b1;
    next_cycle();
    resp_ready = 1'b0;
    check_flag("resp_valid", resp_valid, 1'b0);
    check_flag("cmd_ready", cmd_ready, 1'b1);
  endtask

  task automatic give_crossings(int n);
    int hi;
    for (int i = 0; i < n; i++) begin
      cntr_ir = 1'b1;
      hi = 5 + ($random(seed) & 7);        // Long dwell on the line
      repeat (hi) next_cycle();
      cntr_ir = 1'b0;
      repeat (4) next_cycle();
    end
  endtask

  task automatic run_move(opcode_t op, squares_t sq);
    logic [7:0] field;
    int         t;
    int         fan_before;
    field      = 8'($random(seed));
    heading    = desired_heading(field) + 12'h400;   // Far off the line
    fan_before = n_fanfare;
    send_cmd({op, field, sq});
    check_flag("moving", moving, 1'b1);
    for (int ph = 0; ph < 3; ph++) begin            // Left, right, neither
      lft_ir  = (ph == 0);
      rght_ir = (ph == 1);
      repeat (3) next_cycle();                      // Through the synchronizer
      repeat (4) begin
        heading = heading_t'($random(seed));
        next_cycle();
        check_error(error, exp_error(heading, field, lft_ir, rght_ir));
      end
    end
    heading = desired_heading(field);               // Aligned, ramp may start
    t = 0;
    while ((op == FANFARE) ? !frwrd[5] : (frwrd[9:8] != 2'b11)) begin
      next_cycle();
      t++;
      if (t > 400)
        timed_out("speed ramp");
    end
    if (op == FANFARE)
      set_rdy(1'b0);                    // Odd step count, so the fall clamps
    else
      repeat (8) next_cycle();          // Sit at saturation a while
    give_crossings(2 * sq);
    set_rdy(1'b1);
    t = 0;
    while (moving) begin
      next_cycle();
      t++;
      if (t > 400)
        timed_out("moving to fall");
    end
    check_speed(frwrd, '0);
    take_response(1'b0);
    if (n_fanfare - fan_before != ((op == FANFARE) ? 1 : 0)) begin
      $display("fanfare_go pulsed %0d times for opcode %h", n_fanfare - fan_before, op);
      stop_on_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int n;
    clk = 1'b0;
    rst_n = 1'b0;
    cmd = '0;
    cmd_valid = 1'b0;
    resp_ready = 1'b0;
    cal_done = 1'b0;
    heading = '0;
    heading_rdy = 1'b0;
    lft_ir = 1'b0;
    cntr_ir = 1'b0;
    rght_ir = 1'b0;
    rdy_en = 1'b1;
    n_cal = 0;
    n_tour = 0;
    n_fanfare = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    next_cycle();

    // Quiet outputs out of reset
    check_flag("strt_cal", strt_cal, 1'b0);
    check_flag("tour_go", tour_go, 1'b0);
    check_flag("fanfare_go", fanfare_go, 1'b0);
    check_flag("moving", moving, 1'b0);
    check_flag("resp_valid", resp_valid, 1'b0);
    check_flag("cmd_ready", cmd_ready, 1'b1);
    check_speed(frwrd, '0);

    // Calibration
    send_cmd({CAL, 12'(seed)});
    check_flag("strt_cal", strt_cal, 1'b1);
    n = 3 + ($random(seed) & 7);
    repeat (n) begin
      next_cycle();
      check_flag("strt_cal", strt_cal, 1'b0);
      check_flag("resp_valid", resp_valid, 1'b0);
    end
    cal_done = 1'b1;
    next_cycle();
    cal_done = 1'b0;
    take_response(1'b1);
    if (n_cal != 1) begin
      $display("strt_cal pulsed %0d times for one calibration", n_cal);
      stop_on_failure();
    end

    // Tour hand-off, no response
    send_cmd({TOUR, 12'(seed)});
    check_flag("tour_go", tour_go, 1'b1);
    check_flag("cmd_ready", cmd_ready, 1'b0);
    next_cycle();
    check_flag("tour_go", tour_go, 1'b0);
    check_flag("cmd_ready", cmd_ready, 1'b1);
    repeat (30) begin
      check_flag("resp_valid", resp_valid, 1'b0);
      next_cycle();
    end
    if (n_tour != 1) begin
      $display("tour_go pulsed %0d times for one tour", n_tour);
      stop_on_failure();
    end

    run_move(MOVE, 4'd2);
    run_move(FANFARE, 4'd1);

    if (!saw_sat || !saw_clamp) begin
      $display("Speed ramp never reached saturation or the zero clamp");
      stop_on_failure();
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

/* list.f */
+incdir+hdl
hdl/knight_pkg.sv
hdl/ir_sync.sv
hdl/square_counter.sv
hdl/heading_err.sv
hdl/speed_ramp.sv
hdl/cmd_proc.sv
hdl/knight_ctrl_top.sv
bench/knight_tb.sv
